// ==== build.f ====
rtl/zx_pkg.sv
rtl/key_matrix.sv
rtl/io_ports.sv
rtl/mem_pager.sv
rtl/zx_io.sv
test/zx_io_asserts.sv
test/tb_zx_io.sv

// ==== rtl/io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_ports
    import zx_pkg::*;
(
    input  logic       clk28,
    input  logic       rst_n,
    input  cpu_bus_t   bus,
    input  machine_t   machine,
    input  logic       magic_map,
    input  logic       en_kempston,
    input  logic       en_sinclair,
    input  logic [4:0] kd,
    input  logic [7:0] kempston_data,
    input  logic       tape_in,
    input  logic       port_ff_active,
    input  logic [7:0] port_ff_data,
    output logic [7:0] d_out,
    output logic       d_out_active,
    output port_regs_t regs
);

    logic       rd_cycle;
    logic       wr_cycle;
    logic       fe_cs;
    logic       ff_cs;
    logic       kempston_cs;
    logic       p7ffd_cs;
    logic       p7ffd_open;
    logic       dffd_cs;
    logic       p1ffd_cs;
    logic       fdc_cs;
    logic       fe_rd;
    logic       ff_rd;
    logic       kempston_rd;
    logic [4:0] joy_mask_next;
    logic [4:0] joy_mask;
    port_regs_t r;

    // a valid access has exactly one strobe
    assign rd_cycle = bus.ioreq && bus.rd && !bus.wr;
    assign wr_cycle = bus.ioreq && bus.wr && !bus.rd;

    assign fe_cs = !bus.a[0];
    assign ff_cs = port_ff_active && (machine != MACHINE_S3) &&
                   (machine != MACHINE_PENT || bus.a[7:0] == 8'hFF);
    assign kempston_cs = en_kempston && ((bus.a[7:0] & KEMPSTON_MASK) == 8'h00);

    // on +3 and under magic_map the #1ffd family must not alias onto #7ffd
    assign p7ffd_cs = !bus.a[1] && !bus.a[15] &&
                      (bus.a[14] || (!magic_map && machine != MACHINE_S3)) &&
                      (machine != MACHINE_S48 || magic_map);
    assign p7ffd_open = !r.lock_7ffd || r.port_dffd[4];

    assign dffd_cs  = (bus.a == 16'hDFFD) && (machine == MACHINE_PENT || magic_map);
    assign p1ffd_cs = (bus.a == 16'h1FFD) && (machine == MACHINE_S3 || magic_map);
    assign fdc_cs   = (bus.a == 16'h2FFD || bus.a == 16'h3FFD) && (machine == MACHINE_S3);

    // sinclair joystick on the 6-0 and b-space rows
    always_comb begin
        joy_mask_next = 5'b11111;
        if (en_sinclair && !bus.a[12]) begin
            joy_mask_next = joy_mask_next & ~{kempston_data[1], kempston_data[0],
                                              kempston_data[2], kempston_data[3],
                                              kempston_data[4]};
        end
        if (en_sinclair && !bus.a[15]) begin
            joy_mask_next = joy_mask_next & ~{1'b0, kempston_data[6], kempston_data[5],
                                              2'b00};  // n and m.
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            joy_mask    <= 5'b11111;
            fe_rd       <= 1'b0;
            ff_rd       <= 1'b0;
            kempston_rd <= 1'b0;
        end else begin
            joy_mask    <= joy_mask_next;  // lines up with the scanner register.
            fe_rd       <= rd_cycle && fe_cs;
            ff_rd       <= rd_cycle && ff_cs;
            kempston_rd <= rd_cycle && kempston_cs;
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            r <= REGS_RESET;
        end else begin
            if (wr_cycle && fe_cs) begin
                r.beeper   <= bus.d[4];
                r.tape_out <= bus.d[3];
                r.border   <= bus.d[2:0];
            end
            if (wr_cycle && p7ffd_cs && p7ffd_open) begin
                r.rampage128 <= bus.d[2:0];
                r.screenpage <= bus.d[3];
                r.rompage128 <= bus.d[4];
                r.lock_7ffd  <= bus.d[5];
            end
            if (wr_cycle && dffd_cs) begin
                r.port_dffd <= bus.d[4:0];
            end
            if (wr_cycle && p1ffd_cs) begin
                r.port_1ffd <= bus.d[2:0];
                r.plus3_mtr <= !bus.d[3];   // motor on when bit 3 set.
            end
            r.plus3_drd <= !(rd_cycle && fdc_cs);
            r.plus3_dwr <= !(wr_cycle && fdc_cs);
        end
    end

    assign regs = r;

    // kempston first, then #fe, then the floating bus
    always_comb begin
        if (kempston_rd) begin
            d_out = kempston_data;
        end else if (fe_rd) begin
            d_out = {1'b1, tape_in, 1'b1, kd & joy_mask};
        end else begin
            d_out = port_ff_data;
        end
    end

    assign d_out_active = fe_rd || ff_rd || kempston_rd;

endmodule

`default_nettype wire

// ==== rtl/key_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_matrix
    import zx_pkg::*;
(
    input  logic                 clk28,
    input  logic                 rst_n,
    input  logic [7:0]           addr_hi,
    input  logic [ROWS*COLS-1:0] keys,
    output logic [COLS-1:0]      kd
);

    logic [COLS-1:0] kd_next;

    // every half-row with a low address line pulls its pressed keys down
    always_comb begin
        kd_next = '1;
        for (int row = 0; row < ROWS; row++) begin
            if (!addr_hi[row]) begin
                kd_next = kd_next & keys[row*COLS +: COLS];
            end
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            kd <= '1;            // no key pressed.
        end else begin
            kd <= kd_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_pager.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pager
    import zx_pkg::*;
(
    input  port_regs_t regs,
    input  machine_t   machine,
    input  logic [1:0] slot,
    output mem_page_t  page
);

    logic [1:0] rom_num;
    logic [5:0] ram_sel;
    logic [2:0] special_bank;
    logic       all_ram;

    always_comb begin
        case (machine)
            MACHINE_S3:   rom_num = {regs.port_1ffd[2], regs.rompage128};
            MACHINE_S128: rom_num = {1'b0, regs.rompage128};
            MACHINE_PENT: rom_num = {1'b0, regs.rompage128};
            default:      rom_num = 2'd0;
        endcase
    end

    // pentagon extends the #7ffd page with the low bits of #dffd
    assign ram_sel = (machine == MACHINE_PENT) ? {regs.port_dffd[2:0], regs.rampage128}
                                               : {3'b000, regs.rampage128};

    assign all_ram = (machine == MACHINE_S3) && regs.port_1ffd[0];

    always_comb begin
        case (regs.port_1ffd[2:1])
            2'd0: special_bank = {1'b0, slot};                              // 0-1-2-3.
            2'd1: special_bank = {1'b1, slot};                              // 4-5-6-7.
            2'd2: special_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};      // 4-5-6-3.
            default: begin                                                  // 4-7-6-3.
                if (slot == 2'd3) begin
                    special_bank = 3'd3;
                end else if (slot == 2'd1) begin
                    special_bank = 3'd7;
                end else begin
                    special_bank = {1'b1, slot};
                end
            end
        endcase
    end

    always_comb begin
        if (all_ram) begin
            page = '{is_rom: 1'b0, page: {3'b000, special_bank}};
        end else begin
            case (slot)
                2'd0:    page = '{is_rom: 1'b1, page: {4'b0000, rom_num}};
                2'd1:    page = '{is_rom: 1'b0, page: 6'd5};
                2'd2:    page = '{is_rom: 1'b0, page: 6'd2};
                default: page = '{is_rom: 1'b0, page: ram_sel};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/zx_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_io
    import zx_pkg::*;
(
    input  logic                 clk28,
    input  logic                 rst_n,
    input  cpu_bus_t             bus,
    input  machine_t             machine,
    input  logic                 magic_map,
    input  logic                 en_kempston,
    input  logic                 en_sinclair,
    input  logic [ROWS*COLS-1:0] keys,
    input  logic [7:0]           kempston_data,
    input  logic                 tape_in,
    input  logic                 port_ff_active,
    input  logic [7:0]           port_ff_data,
    output logic [7:0]           d_out,
    output logic                 d_out_active,
    output port_regs_t           regs,
    output mem_page_t            page
);

    logic [COLS-1:0] kd;

    key_matrix key_matrix_i (
        .clk28   (clk28),
        .rst_n   (rst_n),
        .addr_hi (bus.a[15:8]),
        .keys    (keys),
        .kd      (kd)
    );

    io_ports io_ports_i (
        .clk28          (clk28),
        .rst_n          (rst_n),
        .bus            (bus),
        .machine        (machine),
        .magic_map      (magic_map),
        .en_kempston    (en_kempston),
        .en_sinclair    (en_sinclair),
        .kd             (kd),
        .kempston_data  (kempston_data),
        .tape_in        (tape_in),
        .port_ff_active (port_ff_active),
        .port_ff_data   (port_ff_data),
        .d_out          (d_out),
        .d_out_active   (d_out_active),
        .regs           (regs)
    );

    mem_pager mem_pager_i (
        .regs    (regs),
        .machine (machine),
        .slot    (bus.a[15:14]),  // 16k slot of the current address.
        .page    (page)
    );

endmodule

`default_nettype wire

// ==== rtl/zx_pkg.sv ====
`default_nettype none

package zx_pkg;

    typedef enum logic [1:0] {
        MACHINE_S48  = 2'd0,
        MACHINE_S128 = 2'd1,
        MACHINE_S3   = 2'd2,
        MACHINE_PENT = 2'd3
    } machine_t;

    typedef struct packed {
        logic [15:0] a;
        logic [7:0]  d;
        logic        rd;
        logic        wr;
        logic        ioreq;
    } cpu_bus_t;

    typedef struct packed {
        logic [2:0] border;
        logic       beeper;
        logic       tape_out;
        logic       screenpage;
        logic       rompage128;
        logic [2:0] rampage128;
        logic       lock_7ffd;
        logic [4:0] port_dffd;   // 2:0 extended ram page, 4 unlocks #7ffd.
        logic [2:0] port_1ffd;
        logic       plus3_mtr;   // active low.
        logic       plus3_drd;   // active low.
        logic       plus3_dwr;   // active low.
    } port_regs_t;

    typedef struct packed {
        logic       is_rom;
        logic [5:0] page;        // ram bank, or rom number in 1:0.
    } mem_page_t;

    localparam logic [7:0] KEMPSTON_MASK = 8'hE0;  // a7..a5 must be zero.
    localparam int ROWS = 8;
    localparam int COLS = 5;

    localparam port_regs_t REGS_RESET = '{
        plus3_mtr: 1'b1,
        plus3_drd: 1'b1,
        plus3_dwr: 1'b1,
        default:   '0
    };

endpackage

`default_nettype wire

// ==== test/io_cases.txt ====
# op mach magic kemp sinc addr data keys joy tape ff_act ff_data exp_dout exp_regs exp_page
# op 0 write, 1 read, 2 read with no responder, 3 page check; mach 0 48k 1 128k 2 +3 3 pent
3 1 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 000007 00
0 1 0 0 0 00FE 1D FFFFFFFFFF 00 0 0 00 00 2E0007 40
1 1 0 0 0 FEFE 00 FFFFFFFFF6 00 1 0 00 F6 2E0007 00
1 1 0 0 0 EEFE 00 FFFEFF83FE 00 0 0 00 AE 2E0007 00
0 1 0 0 0 7FFD 13 FFFFFFFFFF 00 0 0 00 00 2EB007 05
3 1 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2EB007 03
3 1 0 0 0 0000 00 FFFFFFFFFF 00 0 0 00 00 2EB007 41
3 1 0 0 0 8000 00 FFFFFFFFFF 00 0 0 00 00 2EB007 02
0 1 0 0 0 7FFD 2E FFFFFFFFFF 00 0 0 00 00 2F6807 05
0 1 0 0 0 7FFD 01 FFFFFFFFFF 00 0 0 00 00 2F6807 05
3 1 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2F6807 06
# pentagon lock override, extended page and floating bus
0 3 0 0 0 DFFD 10 FFFFFFFFFF 00 0 0 00 00 2F6C07 06
0 3 0 0 0 7FFD 25 FFFFFFFFFF 00 0 0 00 00 2E5C07 05
0 3 0 0 0 DFFD 03 FFFFFFFFFF 00 0 0 00 00 2E58C7 1D
0 3 0 0 0 7FFD 02 FFFFFFFFFF 00 0 0 00 00 2E58C7 05
3 3 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E58C7 1D
3 3 0 0 0 0000 00 FFFFFFFFFF 00 0 0 00 00 2E58C7 40
1 3 0 0 0 00FF 00 FFFFFFFFFF 00 0 1 A5 A5 2E58C7 40
2 3 0 0 0 00FD 00 FFFFFFFFFF 00 0 1 A5 00 2E58C7 40
0 3 0 0 0 DFFD 10 FFFFFFFFFF 00 0 0 00 00 2E5C07 05
0 3 0 0 0 7FFD 00 FFFFFFFFFF 00 0 0 00 00 2E0407 05
0 3 0 0 0 DFFD 00 FFFFFFFFFF 00 0 0 00 00 2E0007 00
# 48k with and without magic_map
1 0 0 0 0 0001 00 FFFFFFFFFF 00 0 1 5A 5A 2E0007 40
0 0 0 0 0 7FFD 07 FFFFFFFFFF 00 0 0 00 00 2E0007 05
3 0 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E0007 00
0 0 1 0 0 7FFD 07 FFFFFFFFFF 00 0 0 00 00 2E7007 05
3 0 1 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E7007 07
3 0 1 0 0 0000 00 FFFFFFFFFF 00 0 0 00 00 2E7007 40
# +3 rom number, all-ram layouts, motor and fdc strobes
0 2 0 0 0 7FFD 10 FFFFFFFFFF 00 0 0 00 00 2E8007 05
0 2 0 0 0 1FFD 04 FFFFFFFFFF 00 0 0 00 00 2E8027 43
0 2 0 0 0 1FFD 0D FFFFFFFFFF 00 0 0 00 00 2E802B 04
3 2 0 0 0 4000 00 FFFFFFFFFF 00 0 0 00 00 2E802B 05
3 2 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E802B 03
0 2 0 0 0 1FFD 07 FFFFFFFFFF 00 0 0 00 00 2E803F 04
3 2 0 0 0 4000 00 FFFFFFFFFF 00 0 0 00 00 2E803F 07
3 2 0 0 0 8000 00 FFFFFFFFFF 00 0 0 00 00 2E803F 06
0 2 0 0 0 1FFD 01 FFFFFFFFFF 00 0 0 00 00 2E800F 00
3 2 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E800F 03
0 2 0 0 0 1FFD 03 FFFFFFFFFF 00 0 0 00 00 2E801F 04
3 2 0 0 0 C000 00 FFFFFFFFFF 00 0 0 00 00 2E801F 07
0 2 0 0 0 1FFD 00 FFFFFFFFFF 00 0 0 00 00 2E8007 41
2 2 0 0 0 2FFD 00 FFFFFFFFFF 00 0 1 A5 00 2E8005 41
0 2 0 0 0 3FFD 55 FFFFFFFFFF 00 0 0 00 00 2E8006 41
2 2 0 0 0 00FF 00 FFFFFFFFFF 00 0 1 A5 00 2E8007 41
# kempston and sinclair joysticks on 128k
1 1 0 1 0 001F 00 FFFFFFFFFF 13 0 0 00 13 2E8007 41
1 1 0 1 0 001E 00 FFFFFFFFFF 0A 0 0 00 0A 2E8007 41
1 1 0 0 1 EFFE 00 FFFFFFFFFF 05 0 0 00 B3 2E8007 00
1 1 0 0 1 7FFE 00 FFFFFFFFFF 60 0 0 00 B3 2E8007 05
1 1 0 0 1 F7FE 00 FFFFFFFFFF 1F 0 0 00 BF 2E8007 00
1 1 0 0 0 EFFE 00 FFFFFFFFFF 1F 0 0 00 BF 2E8007 00

// ==== test/tb_zx_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zx_io
    import zx_pkg::*;
();

    typedef struct packed {
        logic [1:0]  op;          // 0 write, 1 read, 2 unanswered read, 3 page check.
        machine_t    machine;
        logic        magic_map;
        logic        en_kempston;
        logic        en_sinclair;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [39:0] keys;
        logic [7:0]  joy;
        logic        tape_in;
        logic        ff_active;
        logic [7:0]  ff_data;
        logic [7:0]  exp_dout;
        port_regs_t  exp_regs;
        mem_page_t   exp_page;
    } step_t;

    logic                 clk28;
    logic                 rst_n;
    cpu_bus_t             bus;
    machine_t             machine;
    logic                 magic_map;
    logic                 en_kempston;
    logic                 en_sinclair;
    logic [ROWS*COLS-1:0] keys;
    logic [7:0]           kempston_data;
    logic                 tape_in;
    logic                 port_ff_active;
    logic [7:0]           port_ff_data;
    logic [7:0]           d_out;
    logic                 d_out_active;
    port_regs_t           regs;
    mem_page_t            page;

    step_t steps[$];
    bit    loaded;
    int    data_errors;
    int    regs_errors;
    int    page_errors;
    int    ack_errors;
    int    setup_errors;

    zx_io dut_i (
        .clk28          (clk28),
        .rst_n          (rst_n),
        .bus            (bus),
        .machine        (machine),
        .magic_map      (magic_map),
        .en_kempston    (en_kempston),
        .en_sinclair    (en_sinclair),
        .keys           (keys),
        .kempston_data  (kempston_data),
        .tape_in        (tape_in),
        .port_ff_active (port_ff_active),
        .port_ff_data   (port_ff_data),
        .d_out          (d_out),
        .d_out_active   (d_out_active),
        .regs           (regs),
        .page           (page)
    );

    bind io_ports zx_io_asserts zx_io_asserts_i (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .rd_cycle     (rd_cycle),
        .wr_cycle     (wr_cycle),
        .p7ffd_cs     (p7ffd_cs),
        .d_out_active (d_out_active),
        .regs         (regs)
    );

    initial begin
        clk28 = 1'b0;
        forever #10 clk28 = ~clk28;    // 20 ns period.
    end

    initial begin
        wait (loaded);
        #(steps.size() * 80 + 1000);   // four cycles per step plus 1 us.
        $display("watchdog expired before all %0d steps finished", steps.size());
        $display("=== FAIL ===");
        $finish;
    end

    task automatic load_steps();
        int          fd;
        int          n;
        string       line;
        logic [63:0] col [15];
        step_t       s;
        fd = $fopen("test/io_cases.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("could not open the case file test/io_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;              // blank or comment line.
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
            if (n != 15) begin
                setup_errors++;
                $display("case line has %0d fields instead of 15: %s", n, line);
                continue;
            end
            s.op          = col[0][1:0];
            s.machine     = machine_t'(col[1][1:0]);
            s.magic_map   = col[2][0];
            s.en_kempston = col[3][0];
            s.en_sinclair = col[4][0];
            s.addr        = col[5][15:0];
            s.data        = col[6][7:0];
            s.keys        = col[7][39:0];
            s.joy         = col[8][7:0];
            s.tape_in     = col[9][0];
            s.ff_active   = col[10][0];
            s.ff_data     = col[11][7:0];
            s.exp_dout    = col[12][7:0];
            s.exp_regs    = port_regs_t'(col[13][21:0]);
            s.exp_page    = mem_page_t'(col[14][6:0]);
            steps.push_back(s);
        end
        $fclose(fd);
    endtask

    task automatic apply_step(input step_t s);
        machine        = s.machine;
        magic_map      = s.magic_map;
        en_kempston    = s.en_kempston;
        en_sinclair    = s.en_sinclair;
        keys           = s.keys;
        kempston_data  = s.joy;
        tape_in        = s.tape_in;
        port_ff_active = s.ff_active;
        port_ff_data   = s.ff_data;
        bus.a          = s.addr;
        bus.d          = s.data;
        bus.wr         = (s.op == 2'd0);
        bus.rd         = (s.op == 2'd1 || s.op == 2'd2);
        bus.ioreq      = (s.op != 2'd3);
    endtask

    task automatic idle_bus();
        bus.rd    = 1'b0;
        bus.wr    = 1'b0;
        bus.ioreq = 1'b0;              // address stays for the page lookup.
    endtask

    task automatic check_data(input int idx, input string name,
                              input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] step %0d %s got %h expected %h", idx, name, got, exp);
        end
    endtask

    task automatic check_regs(input int idx, input port_regs_t got, input port_regs_t exp);
        if (got !== exp) begin
            regs_errors++;
            $display("[ERROR] step %0d regs got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_page(input int idx, input mem_page_t got, input mem_page_t exp);
        if (got !== exp) begin
            page_errors++;
            $display("[ERROR] step %0d page got %h expected %h", idx, got, exp);
        end
    endtask

    // one cycle of access, then the check and one idle cycle
    task automatic run_step(input int idx, input step_t s);
        apply_step(s);
        @(negedge clk28);
        if (s.op == 2'd1) begin
            if (!d_out_active) begin
                ack_errors++;
                $display("step %0d: read at address %h was not acknowledged", idx, s.addr);
            end else begin
                check_data(idx, "d_out", d_out, s.exp_dout);
            end
        end else if (d_out_active) begin
            ack_errors++;
            $display("step %0d: d_out_active is high with no answering port at address %h",
                     idx, s.addr);
        end
        check_regs(idx, regs, s.exp_regs);
        check_page(idx, page, s.exp_page);
        idle_bus();
        @(negedge clk28);
    endtask

    initial begin
        int total;
        int assert_errors;
        rst_n          = 1'b0;
        bus            = '0;
        machine        = MACHINE_S48;
        magic_map      = 1'b0;
        en_kempston    = 1'b0;
        en_sinclair    = 1'b0;
        keys           = '1;           // no key pressed.
        kempston_data  = 8'h00;
        tape_in        = 1'b0;
        port_ff_active = 1'b0;
        port_ff_data   = 8'h00;
        load_steps();
        if (steps.size() == 0) begin
            setup_errors++;
            $display("no test steps were loaded");
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk28);
        @(negedge clk28);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(i + 1, steps[i]);
        end
        assert_errors = dut_i.io_ports_i.zx_io_asserts_i.fail_count;
        total = data_errors + regs_errors + page_errors + ack_errors + setup_errors +
                assert_errors;
        $display("errors: data %0d, regs %0d, page %0d, ack %0d, setup %0d, assertions %0d",
                 data_errors, regs_errors, page_errors, ack_errors, setup_errors,
                 assert_errors);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/zx_io_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_io_asserts
    import zx_pkg::*;
(
    input logic       clk28,
    input logic       rst_n,
    input logic       rd_cycle,
    input logic       wr_cycle,
    input logic       p7ffd_cs,
    input logic       d_out_active,
    input port_regs_t regs
);

    int fail_count;

    initial fail_count = 0;

    ack_follows_read: assert property (@(posedge clk28) disable iff (!rst_n)
        $rose(d_out_active) |-> $past(rd_cycle))
        else begin
            fail_count++;
            $error("d_out_active rose without a read cycle on the previous edge");
        end

    fdc_strobes_exclusive: assert property (@(posedge clk28) disable iff (!rst_n)
        regs.plus3_drd || regs.plus3_dwr)
        else begin
            fail_count++;
            $error("plus3_drd and plus3_dwr are low together");
        end

    lock_needs_7ffd_write: assert property (@(posedge clk28) disable iff (!rst_n)
        $rose(regs.lock_7ffd) |-> $past(wr_cycle && p7ffd_cs))
        else begin
            fail_count++;
            $error("lock_7ffd rose without a #7ffd write");
        end

    // strobes and motor idle high, everything else zero
    regs_held_in_reset: assert property (@(posedge clk28)
        !rst_n |=> regs == port_regs_t'(22'h000007))
        else begin
            fail_count++;
            $error("regs left their reset value while rst_n is low");
        end

endmodule

`default_nettype wire
